//--- rtl/analogizer_pkg.sv
/*
 * Shared types and constants for the Analogizer video adapter
 * Settings word layout, video type codes and data widths
 */
`default_nettype none

package analogizer_pkg;

	// ------------------------------------------------------------
	// Data widths
	// ------------------------------------------------------------
	localparam int CFG_WORD_W    = 32;  // Bridge data word
	localparam int CFG_MEM_DEPTH = 16;  // Words behind the settings base
	localparam int CFG_IDX_W     = 4;   // Low address nibble picks the word
	localparam int COLOR_W       = 8;   // Core colour depth per channel
	localparam int DAC_W         = 6;   // Cartridge DAC bits per channel
	localparam int SC_FX_W       = 3;   // Scanline effect code

	// ------------------------------------------------------------
	// Controller types
	// ------------------------------------------------------------
	// Codes from here upward wire the SNAC port as Conf B
	localparam logic [4:0] CONF_B_TYPE       = 5'd16;
	localparam logic [4:0] CONF_A_EXTRA_TYPE = 5'd20;  // Lone Conf A code above the split

	// Analog output format
	// Codes 5 to 9 were scandoubler modes and now only set the scanline effect
	typedef enum logic [3:0] {
		VT_RGBS     = 4'd0,  // Composite sync on the H pin
		VT_RGSB     = 4'd1,  // Sync on green through the SOG switch
		VT_SD_FIRST = 4'd5,
		VT_SD_LAST  = 4'd9
	} video_type_t;

	// ------------------------------------------------------------
	// Settings word
	// ------------------------------------------------------------
	typedef struct packed {
		logic        busy;          // Set by the adapter while in reset
		logic [14:0] rsvd_hi;
		logic        osd;           // OSD request
		logic        blank_screen;  // Blank the Pocket screen
		video_type_t video_type;
		logic [3:0]  cont_assign;   // Controller to player routing
		logic        rsvd_lo;
		logic [4:0]  cont_type;     // SNAC controller type
	} analogizer_cfg_s;

	// Same 32 bits seen by the bridge as a word and by the decoder as fields
	typedef union packed {
		logic [CFG_WORD_W-1:0] raw;
		analogizer_cfg_s       f;
	} analogizer_cfg_u;

endpackage

`default_nettype wire

//--- rtl/config_bridge.sv
/*
 * Bridge slave for the adapter settings
 * Settings word at offset 0, word store above it, byte order swap
 */
`default_nettype none
`timescale 1ns/10ps

module config_bridge import analogizer_pkg::*; #(
	parameter logic [7:0] ADDRESS_CONFIG = 8'hF7
) (
	input  wire                   i_clk,
	input  wire                   i_rst_apf,
	input  wire                   i_bridge_endian_little,
	input  wire  [CFG_WORD_W-1:0] i_bridge_addr,
	input  wire                   i_bridge_rd,
	input  wire                   i_bridge_wr,
	input  wire  [CFG_WORD_W-1:0] i_bridge_wr_data,
	output logic [CFG_WORD_W-1:0] o_bridge_rd_data,
	output analogizer_cfg_u       o_cfg
);

	// Big-endian hosts see every word byte reversed in both directions
	function automatic logic [CFG_WORD_W-1:0] host_order(
		input logic [CFG_WORD_W-1:0] w,
		input logic                  little
	);
		return little ? w : {<<8{w}};
	endfunction

	logic                  sel;      // Upper address byte hits this block
	logic                  wr_hit;
	logic                  rd_hit;
	logic [CFG_IDX_W-1:0]  idx;
	logic [CFG_WORD_W-1:0] wr_word;  // Write data in adapter byte order
	logic [CFG_WORD_W-1:0] rd_word;
	analogizer_cfg_u       cfg_q;    // Settings as written
	logic [CFG_WORD_W-1:0] cfg_d;    // One stage toward the decoder
	logic [CFG_WORD_W-1:0] cfg_mem [CFG_MEM_DEPTH];

	assign sel     = (i_bridge_addr[CFG_WORD_W-1 -: 8] == ADDRESS_CONFIG);
	assign wr_hit  = i_bridge_wr & sel;
	assign rd_hit  = i_bridge_rd & sel;
	assign idx     = i_bridge_addr[CFG_IDX_W-1:0];
	assign wr_word = host_order(i_bridge_wr_data, i_bridge_endian_little);
	assign rd_word = (idx == '0) ? cfg_q.raw : cfg_mem[idx];

	// ------------------------------------------------------------
	// Write side
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			cfg_q.raw <= '0;
		end else if (wr_hit && idx == '0) begin
			cfg_q.raw <= wr_word;
		end
	end

	// Store words 1 to 15, entry 0 shadows the settings register
	always_ff @(posedge i_clk) begin
		if (wr_hit && idx != '0) begin
			cfg_mem[idx] <= wr_word;
		end
	end

	// ------------------------------------------------------------
	// Read side
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (rd_hit) begin
			o_bridge_rd_data <= host_order(rd_word, i_bridge_endian_little);  // Held until next read
		end
	end

	// Output stage keeps the settings two edges behind the write
	always_ff @(posedge i_clk) begin
		cfg_d <= {i_rst_apf, cfg_q.raw[CFG_WORD_W-2:0]};  // Top bit remembers last reset cycle
	end

	// Busy covers reset itself and the first cycle after it
	always_comb begin
		o_cfg.raw                 = cfg_d;
		o_cfg.raw[CFG_WORD_W-1]   = cfg_d[CFG_WORD_W-1] | i_rst_apf;
	end

endmodule

`default_nettype wire

//--- rtl/settings_decode.sv
/*
 * Settings word decode into registered adapter controls
 * Conf A/B select and scanline effect derivation
 */
`default_nettype none
`timescale 1ns/10ps

module settings_decode import analogizer_pkg::*; (
	input  wire                  i_clk,
	input  wire analogizer_cfg_u i_cfg,
	output logic [4:0]           o_cont_type,
	output logic [3:0]           o_cont_assign,
	output video_type_t          o_video_type,
	output logic [SC_FX_W-1:0]   o_sc_fx,
	output logic                 o_blank_screen,
	output logic                 o_osd,
	output logic                 o_conf_b,
	output logic                 o_busy
);

	logic       sd_mode;  // Old scandoubler code selected
	logic [3:0] sd_idx;

	assign sd_mode = (i_cfg.f.video_type >= VT_SD_FIRST) &&
	                 (i_cfg.f.video_type <= VT_SD_LAST);
	assign sd_idx  = 4'(i_cfg.f.video_type - VT_SD_FIRST);  // 0 off, 1 to 3 scanlines, 4 hq2x

	// ------------------------------------------------------------
	// Field registers
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		o_cont_type    <= i_cfg.f.cont_type;
		o_cont_assign  <= i_cfg.f.cont_assign;
		o_video_type   <= i_cfg.f.video_type;
		o_blank_screen <= i_cfg.f.blank_screen;
		o_osd          <= i_cfg.f.osd;
		o_busy         <= i_cfg.f.busy;
	end

	// Conf B for the upper controller codes except the lone Conf A one
	always_ff @(posedge i_clk) begin
		o_conf_b <= (o_cont_type >= CONF_B_TYPE) && (o_cont_type != CONF_A_EXTRA_TYPE);
	end

	// Effect follows the last scandoubler code, other types keep it
	always_ff @(posedge i_clk) begin
		if (i_cfg.f.busy) begin
			o_sc_fx <= '0;  // Busy only during and right after reset
		end else if (sd_mode) begin
			o_sc_fx <= sd_idx[SC_FX_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/sync_polarity_fix.sv
/*
 * Sync polarity detector that turns any sync active high
 */
`default_nettype none
`timescale 1ns/10ps

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = 32
) (
	input  wire  i_clk,
	input  wire  i_rst_apf,
	input  wire  i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;   // Two stage delayed sync
	logic [SYNC_CNT_W-1:0] cnt;  // Low time minus high time in one period
	logic                  pol;  // 1 when the input is active low

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			s1  <= 1'b0;
			s2  <= 1'b0;
			cnt <= '0;
			pol <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			if (s1 && !s2) begin
				// Period done, longer high than low gives a negative count
				cnt <= '0;
				pol <= cnt[SYNC_CNT_W-1];
			end else if (s2) begin
				cnt <= cnt - 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/pixel_capture.sv
/*
 * Pixel sampler on the rising edge of the core pixel enable
 * Holds colour, syncs and blanks between pixels
 */
`default_nettype none
`timescale 1ns/10ps

module pixel_capture import analogizer_pkg::*; (
	input  wire                i_clk,
	input  wire                i_rst_apf,
	input  wire                i_ce_pix,
	input  wire  [COLOR_W-1:0] i_r,
	input  wire  [COLOR_W-1:0] i_g,
	input  wire  [COLOR_W-1:0] i_b,
	input  wire                i_hblank,
	input  wire                i_vblank,
	input  wire                i_hs,
	input  wire                i_vs,
	output logic [COLOR_W-1:0] o_r,
	output logic [COLOR_W-1:0] o_g,
	output logic [COLOR_W-1:0] o_b,
	output logic               o_hs,
	output logic               o_vs,
	output logic               o_hbl,
	output logic               o_vbl
);

	logic ce_d;      // Pixel enable one clock ago
	logic pix_edge;

	assign pix_edge = i_ce_pix & ~ce_d;

	// ------------------------------------------------------------
	// Timing signals
	// ------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst_apf) begin
			ce_d  <= 1'b0;
			o_hs  <= 1'b0;
			o_vs  <= 1'b0;
			o_hbl <= 1'b1;  // Start blanked
			o_vbl <= 1'b1;
		end else begin
			ce_d <= i_ce_pix;
			if (pix_edge) begin
				o_hs  <= i_hs;      // Already polarity fixed
				o_vs  <= i_vs;
				o_hbl <= i_hblank;
				o_vbl <= i_vblank;
			end
		end
	end

	// Colour
	always_ff @(posedge i_clk) begin
		if (pix_edge) begin
			o_r <= i_r;
			o_g <= i_g;
			o_b <= i_b;
		end
	end

endmodule

`default_nettype wire

//--- rtl/video_mux.sv
/*
 * Analog output format select for the cartridge DAC
 * Composite sync and data enable forming
 */
`default_nettype none
`timescale 1ns/10ps

module video_mux import analogizer_pkg::*; (
	input  wire video_type_t       i_video_type,
	input  wire  [COLOR_W-1:0]     i_r,
	input  wire  [COLOR_W-1:0]     i_g,
	input  wire  [COLOR_W-1:0]     i_b,
	input  wire                    i_hs,
	input  wire                    i_vs,
	input  wire                    i_hbl,
	input  wire                    i_vbl,
	output logic [DAC_W-1:0]       o_r6,
	output logic [DAC_W-1:0]       o_g6,
	output logic [DAC_W-1:0]       o_b6,
	output logic                   o_hsync_out,
	output logic                   o_vsync_out,
	output logic                   o_blank_n
);

	logic             de;     // Active picture
	logic             csync;  // High outside both pulses
	logic [DAC_W-1:0] r_de;
	logic [DAC_W-1:0] g_de;
	logic [DAC_W-1:0] b_de;

	assign de    = ~(i_hbl | i_vbl);
	assign csync = ~(i_hs ^ i_vs);

	// DAC takes the top bits, black outside the picture
	assign r_de = i_r[COLOR_W-1 -: DAC_W] & {DAC_W{de}};
	assign g_de = i_g[COLOR_W-1 -: DAC_W] & {DAC_W{de}};
	assign b_de = i_b[COLOR_W-1 -: DAC_W] & {DAC_W{de}};

	// ------------------------------------------------------------
	// Format select
	// ------------------------------------------------------------
	always_comb begin
		o_r6        = r_de;
		o_g6        = g_de;
		o_b6        = b_de;
		o_hsync_out = 1'b1;
		o_vsync_out = 1'b1;
		o_blank_n   = de;
		case (i_video_type)
			VT_RGBS: begin
				o_hsync_out = csync;  // Composite sync on the H pin
			end
			VT_RGSB: begin
				o_vsync_out = csync;  // DAC sync pin feeds SOG
			end
			default: begin
				// Encoder and scandoubler types have no path here
				o_r6        = '0;
				o_g6        = '0;
				o_b6        = '0;
				o_hsync_out = i_hs;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/analogizer_top.sv
/*
 * Analogizer adapter top level
 * Settings bridge, video path and cartridge bank mapping
 */
`default_nettype none
`timescale 1ns/10ps

module analogizer_top import analogizer_pkg::*; #(
	parameter logic [7:0] ADDRESS_CONFIG = 8'hF7,
	parameter int         SYNC_CNT_W     = 32
) (
	input  wire                   i_clk,
	input  wire                   i_rst_apf,
	input  wire                   i_ena,
	input  wire                   i_bridge_endian_little,
	input  wire  [CFG_WORD_W-1:0] i_bridge_addr,
	input  wire                   i_bridge_rd,
	input  wire                   i_bridge_wr,
	input  wire  [CFG_WORD_W-1:0] i_bridge_wr_data,
	output logic [CFG_WORD_W-1:0] o_bridge_rd_data,
	input  wire  [COLOR_W-1:0]    i_r,
	input  wire  [COLOR_W-1:0]    i_g,
	input  wire  [COLOR_W-1:0]    i_b,
	input  wire                   i_hblank,
	input  wire                   i_vblank,
	input  wire                   i_hsync,
	input  wire                   i_vsync,
	input  wire                   i_ce_pix,
	output logic [4:0]            o_cont_type,
	output logic [3:0]            o_cont_assign,
	output video_type_t           o_video_type,
	output logic [SC_FX_W-1:0]    o_sc_fx,
	output logic                  o_blank_screen,
	output logic                  o_osd,
	output logic                  o_conf_b,
	output logic                  o_busy,
	output wire  [7:0]            o_cart_bank1,
	output wire  [7:0]            o_cart_bank2,
	output wire  [7:0]            o_cart_bank3,
	output wire                   o_cart_bank1_dir,
	output wire                   o_cart_bank2_dir,
	output wire                   o_cart_bank3_dir,
	output wire                   o_cart_pwroff_reset
);

	analogizer_cfg_u    cfg;
	logic               hs_fix;
	logic               vs_fix;
	logic [COLOR_W-1:0] cap_r;
	logic [COLOR_W-1:0] cap_g;
	logic [COLOR_W-1:0] cap_b;
	logic               cap_hs;
	logic               cap_vs;
	logic               cap_hbl;
	logic               cap_vbl;
	logic [DAC_W-1:0]   r6;
	logic [DAC_W-1:0]   g6;
	logic [DAC_W-1:0]   b6;
	logic               hsync_out;
	logic               vsync_out;
	logic               blank_n;
	logic               cart_on;  // Adapter drives the cartridge port

	// ------------------------------------------------------------
	// Settings
	// ------------------------------------------------------------
	config_bridge #(
		.ADDRESS_CONFIG(ADDRESS_CONFIG)
	) config_bridge_inst (
		.i_clk                 (i_clk),
		.i_rst_apf             (i_rst_apf),
		.i_bridge_endian_little(i_bridge_endian_little),
		.i_bridge_addr         (i_bridge_addr),
		.i_bridge_rd           (i_bridge_rd),
		.i_bridge_wr           (i_bridge_wr),
		.i_bridge_wr_data      (i_bridge_wr_data),
		.o_bridge_rd_data      (o_bridge_rd_data),
		.o_cfg                 (cfg)
	);

	settings_decode settings_decode_inst (
		.i_clk         (i_clk),
		.i_cfg         (cfg),
		.o_cont_type   (o_cont_type),
		.o_cont_assign (o_cont_assign),
		.o_video_type  (o_video_type),
		.o_sc_fx       (o_sc_fx),
		.o_blank_screen(o_blank_screen),
		.o_osd         (o_osd),
		.o_conf_b      (o_conf_b),
		.o_busy        (o_busy)
	);

	// ------------------------------------------------------------
	// Video path
	// ------------------------------------------------------------
	sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) sync_h_inst (
		.i_clk    (i_clk),
		.i_rst_apf(i_rst_apf),
		.i_sync   (i_hsync),
		.o_sync   (hs_fix)
	);

	sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) sync_v_inst (
		.i_clk    (i_clk),
		.i_rst_apf(i_rst_apf),
		.i_sync   (i_vsync),
		.o_sync   (vs_fix)
	);

	pixel_capture pixel_capture_inst (
		.i_clk    (i_clk),
		.i_rst_apf(i_rst_apf),
		.i_ce_pix (i_ce_pix),
		.i_r      (i_r),
		.i_g      (i_g),
		.i_b      (i_b),
		.i_hblank (i_hblank),
		.i_vblank (i_vblank),
		.i_hs     (hs_fix),
		.i_vs     (vs_fix),
		.o_r      (cap_r),
		.o_g      (cap_g),
		.o_b      (cap_b),
		.o_hs     (cap_hs),
		.o_vs     (cap_vs),
		.o_hbl    (cap_hbl),
		.o_vbl    (cap_vbl)
	);

	video_mux video_mux_inst (
		.i_video_type(o_video_type),
		.i_r         (cap_r),
		.i_g         (cap_g),
		.i_b         (cap_b),
		.i_hs        (cap_hs),
		.i_vs        (cap_vs),
		.i_hbl       (cap_hbl),
		.i_vbl       (cap_vbl),
		.o_r6        (r6),
		.o_g6        (g6),
		.o_b6        (b6),
		.o_hsync_out (hsync_out),
		.o_vsync_out (vsync_out),
		.o_blank_n   (blank_n)
	);

	// ------------------------------------------------------------
	// Cartridge banks float as inputs in reset or when disabled
	// ------------------------------------------------------------
	assign cart_on = ~i_rst_apf & i_ena;

	assign o_cart_bank3 = cart_on ? {r6, hsync_out, vsync_out} : 8'hzz;  // Red and both syncs
	assign o_cart_bank2 = cart_on ? {b6[0], blank_n, g6} : 8'hzz;        // Green with blank
	assign o_cart_bank1 = cart_on ? {3'b000, b6[DAC_W-1:1]} : 8'hzz;     // Old SNAC pins held low

	assign o_cart_bank1_dir    = cart_on;
	assign o_cart_bank2_dir    = cart_on;
	assign o_cart_bank3_dir    = cart_on;
	assign o_cart_pwroff_reset = cart_on;  // GPIO use of pin 30

endmodule

`default_nettype wire

//--- verification/analogizer_checker.sv
/*
 * Bound assertions on cartridge direction, power-off pin and busy
 */
`default_nettype none
`timescale 1ns/10ps

module analogizer_checker (
	input wire i_clk,
	input wire i_rst_apf,
	input wire i_ena,
	input wire i_busy,
	input wire i_bank1_dir,
	input wire i_bank2_dir,
	input wire i_bank3_dir,
	input wire i_pwroff_reset
);

	int unsigned fail_cnt = 0;  // Failed assertion count, read by the testbench

	// ------------------------------------------------------------
	// Cartridge port ownership
	// ------------------------------------------------------------
	// Banks must read input whenever the adapter is not driving
	a_dir_float: assert property (@(posedge i_clk)
		(i_rst_apf || !i_ena) |-> !(i_bank1_dir || i_bank2_dir || i_bank3_dir))
	else begin
		fail_cnt++;
		$error("Bank direction set while in reset or disabled");
	end

	a_pwroff_on: assert property (@(posedge i_clk)
		(!i_rst_apf && i_ena) |-> i_pwroff_reset)  // Pin 30 used as GPIO
	else begin
		fail_cnt++;
		$error("Power-off reset low while the adapter is active");
	end

	// Busy follows every reset cycle
	a_busy_reset: assert property (@(posedge i_clk) i_rst_apf |=> i_busy)
	else begin
		fail_cnt++;
		$error("Busy low on the cycle after reset");
	end

endmodule

`default_nettype wire

//--- verification/analogizer_tb.sv
/*
 * Directed testbench for the Analogizer adapter top level
 * Bridge settings and word store, bank mapping, sync polarity
 */
`default_nettype none
`timescale 1ns/10ps

module analogizer_tb import analogizer_pkg::*; ();

	localparam logic [7:0] CFG_BASE     = 8'hF7;
	localparam int         RESET_CYCLES = 8;
	localparam int         LIMIT_CYC    = 2000;  // Whole run needs roughly 600 cycles

	logic                  i_clk;
	logic                  i_rst_apf;
	logic                  i_ena;
	logic                  i_bridge_endian_little;
	logic [CFG_WORD_W-1:0] i_bridge_addr;
	logic                  i_bridge_rd;
	logic                  i_bridge_wr;
	logic [CFG_WORD_W-1:0] i_bridge_wr_data;
	logic [CFG_WORD_W-1:0] o_bridge_rd_data;
	logic [COLOR_W-1:0]    i_r;
	logic [COLOR_W-1:0]    i_g;
	logic [COLOR_W-1:0]    i_b;
	logic                  i_hblank;
	logic                  i_vblank;
	logic                  i_hsync;
	logic                  i_vsync;
	logic                  i_ce_pix;
	logic [4:0]            o_cont_type;
	logic [3:0]            o_cont_assign;
	video_type_t           o_video_type;
	logic [SC_FX_W-1:0]    o_sc_fx;
	logic                  o_blank_screen;
	logic                  o_osd;
	logic                  o_conf_b;
	logic                  o_busy;
	wire  [7:0]            o_cart_bank1;
	wire  [7:0]            o_cart_bank2;
	wire  [7:0]            o_cart_bank3;
	wire                   o_cart_bank1_dir;
	wire                   o_cart_bank2_dir;
	wire                   o_cart_bank3_dir;
	wire                   o_cart_pwroff_reset;
	int unsigned           cycle_cnt;

	// Expected captured pixel and settings state
	logic [COLOR_W-1:0]    m_r;
	logic [COLOR_W-1:0]    m_g;
	logic [COLOR_W-1:0]    m_b;
	logic                  m_hs;   // Active high after the polarity fix
	logic                  m_vs;
	logic                  m_hbl;
	logic                  m_vbl;
	logic [3:0]            m_vt;
	logic [SC_FX_W-1:0]    m_sc_fx;

	analogizer_top #(
		.ADDRESS_CONFIG(CFG_BASE),
		.SYNC_CNT_W    (32)
	) analogizer_top_inst (.*);

	bind analogizer_top analogizer_checker checker_inst (
		.i_clk         (i_clk),
		.i_rst_apf     (i_rst_apf),
		.i_ena         (i_ena),
		.i_busy        (o_busy),
		.i_bank1_dir   (o_cart_bank1_dir),
		.i_bank2_dir   (o_cart_bank2_dir),
		.i_bank3_dir   (o_cart_bank3_dir),
		.i_pwroff_reset(o_cart_pwroff_reset)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;  // 40 ns period
	end

	// ------------------------------------------------------------
	// Reference rules
	// ------------------------------------------------------------
	function automatic logic [CFG_WORD_W-1:0] swap_bytes(input logic [CFG_WORD_W-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Banks 3, 2, 1 from the captured pixel and video type
	function automatic logic [23:0] banks_expected();
		logic       de;
		logic       cs;
		logic [5:0] r6;
		logic [5:0] g6;
		logic [5:0] b6;
		logic       hso;
		logic       vso;
		de  = !(m_hbl || m_vbl);
		cs  = !(m_hs ^ m_vs);          // Low while only one pulse is active
		r6  = de ? m_r[7:2] : 6'd0;
		g6  = de ? m_g[7:2] : 6'd0;
		b6  = de ? m_b[7:2] : 6'd0;
		hso = cs;
		vso = 1'b1;
		if (m_vt == VT_RGSB) begin
			hso = 1'b1;
			vso = cs;
		end else if (m_vt != VT_RGBS) begin
			r6  = '0;                  // No encoder path so the picture is black
			g6  = '0;
			b6  = '0;
			hso = m_hs;
		end
		return {r6, hso, vso, b6[0], de, g6, 3'b000, b6[5:1]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Run stopped at first error");
	endtask

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic word_eq(input string name, input logic [CFG_WORD_W-1:0] got,
			input logic [CFG_WORD_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic field_eq(input string name, input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic vtype_eq(input string name, input video_type_t got, input video_type_t exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic bank_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	task automatic banks_match();
		logic [23:0] e;
		e = banks_expected();
		bank_eq("o_cart_bank3", o_cart_bank3, e[23:16]);
		bank_eq("o_cart_bank2", o_cart_bank2, e[15:8]);
		bank_eq("o_cart_bank1", o_cart_bank1, e[7:0]);
		field_eq("o_cart_bank_dir",
			5'({o_cart_bank3_dir, o_cart_bank2_dir, o_cart_bank1_dir}), 5'd7);
		field_eq("o_cart_pwroff_reset", 5'(o_cart_pwroff_reset), 5'd1);
	endtask

	task automatic banks_float();
		bank_eq("o_cart_bank3", o_cart_bank3, 8'hzz);
		bank_eq("o_cart_bank2", o_cart_bank2, 8'hzz);
		bank_eq("o_cart_bank1", o_cart_bank1, 8'hzz);
		field_eq("o_cart_bank_dir",
			5'({o_cart_bank3_dir, o_cart_bank2_dir, o_cart_bank1_dir}), 5'd0);
		field_eq("o_cart_pwroff_reset", 5'(o_cart_pwroff_reset), 5'd0);
	endtask

	// ------------------------------------------------------------
	// Bridge access
	// ------------------------------------------------------------
	task automatic bridge_write(input logic [3:0] idx, input logic [31:0] data,
			input logic little);
		@(posedge i_clk);
		i_bridge_addr          <= {CFG_BASE, 20'h0, idx};
		i_bridge_wr_data       <= data;
		i_bridge_endian_little <= little;
		i_bridge_wr            <= 1'b1;
		@(posedge i_clk);  // Write edge
		i_bridge_wr <= 1'b0;
	endtask

	task automatic read_word(input logic [3:0] idx, input logic little, output logic [31:0] data);
		@(posedge i_clk);
		i_bridge_addr          <= {CFG_BASE, 20'h0, idx};
		i_bridge_endian_little <= little;
		i_bridge_rd            <= 1'b1;
		@(posedge i_clk);
		i_bridge_rd <= 1'b0;
		@(negedge i_clk);  // Data valid the cycle after the strobe
		data = o_bridge_rd_data;
	endtask

	// Settings write with latency, field and read-back checks
	task automatic write_settings(input logic [4:0] ct, input logic [3:0] ca, input logic [3:0] vt,
			input logic bs, input logic osd, input logic little);
		logic [31:0] w;
		logic [31:0] rd;
		w = {16'h0000, osd, bs, vt, ca, 1'b0, ct};
		bridge_write(4'd0, little ? w : swap_bytes(w), little);
		@(posedge i_clk);
		@(negedge i_clk);
		vtype_eq("o_video_type", o_video_type, video_type_t'(m_vt));  // Not yet through
		@(posedge i_clk);
		@(negedge i_clk);
		m_vt = vt;
		if (vt >= 4'd5 && vt <= 4'd9) begin
			m_sc_fx = 3'(vt - 4'd5);  // Scandoubler codes give the effect
		end
		field_eq("o_cont_type", o_cont_type, ct);
		field_eq("o_cont_assign", 5'(o_cont_assign), 5'(ca));
		vtype_eq("o_video_type", o_video_type, video_type_t'(vt));
		field_eq("o_sc_fx", 5'(o_sc_fx), 5'(m_sc_fx));
		field_eq("o_blank_screen", 5'(o_blank_screen), 5'(bs));
		field_eq("o_osd", 5'(o_osd), 5'(osd));
		field_eq("o_busy", 5'(o_busy), 5'd0);
		@(posedge i_clk);
		@(negedge i_clk);
		// Conf A below 16 and for the lone code 20
		field_eq("o_conf_b", 5'(o_conf_b), 5'(!((ct < 5'd16) || (ct == 5'd20))));
		read_word(4'd0, 1'b1, rd);
		word_eq("o_bridge_rd_data", rd, w);
		read_word(4'd0, 1'b0, rd);
		word_eq("o_bridge_rd_data", rd, swap_bytes(w));
	endtask

	// ------------------------------------------------------------
	// Video stimulus
	// ------------------------------------------------------------
	task automatic send_pixel(input logic hbl, input logic vbl, input logic hs, input logic vs);
		m_r   = 8'($urandom);
		m_g   = 8'($urandom);
		m_b   = 8'($urandom);
		m_hbl = hbl;
		m_vbl = vbl;
		m_hs  = hs;
		m_vs  = vs;
		@(posedge i_clk);
		i_r      <= m_r;
		i_g      <= m_g;
		i_b      <= m_b;
		i_hblank <= hbl;
		i_vblank <= vbl;
		i_hsync  <= hs;
		i_vsync  <= vs;
		i_ce_pix <= 1'b1;
		@(posedge i_clk);  // Capture edge
		i_ce_pix <= 1'b0;
		@(negedge i_clk);
		banks_match();
		@(posedge i_clk);
		i_hsync <= 1'b0;   // Short pulses keep both syncs detected as active high
		i_vsync <= 1'b0;
		repeat (4) @(posedge i_clk);
	endtask

	// Every sync combination followed by blanked pixels
	task automatic pixel_sweep(input logic [3:0] vt);
		logic [2:0] k;
		write_settings(5'd2, 4'd1, vt, 1'b0, 1'b0, 1'b1);
		for (int i = 0; i < 8; i++) begin
			k = 3'(i);
			send_pixel(k[2], k[2] & k[1], k[0], k[1]);
		end
	endtask

	// Four periods of 12 long and 4 short cycles with samples in the last one
	task automatic sync_run(input logic long_lvl);
		for (int p = 0; p < 4; p++) begin
			for (int c = 0; c < 16; c++) begin
				@(posedge i_clk);
				i_hsync  <= (c < 12) ? long_lvl : ~long_lvl;
				i_ce_pix <= (p == 3) && (c == 0 || c == 12);
				if (p == 3 && (c == 1 || c == 13)) begin
					m_hs = (c == 13);  // Short phase is the pulse
					@(negedge i_clk);
					banks_match();
				end
			end
		end
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic reset_and_disable();
		repeat (RESET_CYCLES - 1) @(posedge i_clk);
		@(negedge i_clk);
		banks_float();
		field_eq("o_busy", 5'(o_busy), 5'd1);
		@(posedge i_clk);  // Last reset edge
		i_rst_apf <= 1'b0;
		@(negedge i_clk);
		banks_match();
		field_eq("o_busy", 5'(o_busy), 5'd1);
		@(posedge i_clk);
		@(negedge i_clk);
		field_eq("o_busy", 5'(o_busy), 5'd1);
		@(posedge i_clk);
		@(negedge i_clk);
		field_eq("o_busy", 5'(o_busy), 5'd0);  // Two cycles after release
		field_eq("o_sc_fx", 5'(o_sc_fx), 5'd0);
		@(posedge i_clk);
		i_ena <= 1'b0;
		@(negedge i_clk);
		banks_float();
		@(posedge i_clk);
		i_ena <= 1'b1;
		@(negedge i_clk);
		banks_match();
	endtask

	task automatic settings_access();
		write_settings(5'd3, 4'h2, 4'd6, 1'b1, 1'b0, 1'b1);
		write_settings(5'd17, 4'h9, 4'd9, 1'b0, 1'b1, 1'b0);
		write_settings(5'd20, 4'h5, 4'd3, 1'b1, 1'b1, 1'b1);  // Effect holds
		write_settings(5'd31, 4'hF, 4'd8, 1'b0, 1'b0, 1'b0);
		write_settings(5'd15, 4'h0, 4'd5, 1'b1, 1'b0, 1'b1);
		write_settings(5'd16, 4'h7, 4'd7, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic word_store();
		logic [CFG_WORD_W-1:0] vals [CFG_MEM_DEPTH];
		logic [CFG_WORD_W-1:0] rd;
		for (int i = 1; i < CFG_MEM_DEPTH; i++) begin
			vals[i] = $urandom;  // Adapter byte order
			bridge_write(4'(i), i[0] ? vals[i] : swap_bytes(vals[i]), i[0]);
		end
		for (int i = 1; i < CFG_MEM_DEPTH; i++) begin
			read_word(4'(i), 1'b1, rd);
			word_eq("o_bridge_rd_data", rd, vals[i]);
			read_word(4'(i), 1'b0, rd);
			word_eq("o_bridge_rd_data", rd, swap_bytes(vals[i]));
		end
	endtask

	task automatic polarity_fix();
		write_settings(5'd2, 4'd1, 4'd0, 1'b0, 1'b0, 1'b1);
		@(posedge i_clk);
		i_hblank <= 1'b0;
		i_vblank <= 1'b0;
		m_hbl = 1'b0;
		m_vbl = 1'b0;
		m_vs  = 1'b0;
		sync_run(1'b0);  // Long low and short high
		sync_run(1'b1);  // Inverted input
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		void'($urandom(45523));
		i_rst_apf              = 1'b1;
		i_ena                  = 1'b1;
		i_bridge_endian_little = 1'b1;
		i_bridge_addr          = '0;
		i_bridge_rd            = 1'b0;
		i_bridge_wr            = 1'b0;
		i_bridge_wr_data       = '0;
		i_r                    = '0;
		i_g                    = '0;
		i_b                    = '0;
		i_hblank               = 1'b0;
		i_vblank               = 1'b0;
		i_hsync                = 1'b0;
		i_vsync                = 1'b0;
		i_ce_pix               = 1'b0;
		m_r                    = '0;
		m_g                    = '0;
		m_b                    = '0;
		m_hs                   = 1'b0;
		m_vs                   = 1'b0;
		m_hbl                  = 1'b1;  // Capture starts blanked
		m_vbl                  = 1'b1;
		m_vt                   = 4'd0;
		m_sc_fx                = '0;
		reset_and_disable();
		settings_access();
		word_store();
		pixel_sweep(4'd0);  // RGBS
		pixel_sweep(4'd1);  // RGsB
		pixel_sweep(4'd3);  // Dropped encoder type
		polarity_fix();
		repeat (2) @(posedge i_clk);
		if (analogizer_top_inst.checker_inst.fail_cnt == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abort_run("A checker assertion failed during the run");
		end
	end

	// Watchdog that also stops early on a checker assertion
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < LIMIT_CYC && analogizer_top_inst.checker_inst.fail_cnt == 0) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		if (analogizer_top_inst.checker_inst.fail_cnt != 0) begin
			abort_run("A checker assertion failed during the run");
		end else begin
			abort_run($sformatf("Timeout: tests did not finish within %0d cycles", LIMIT_CYC));
		end
	end

endmodule

`default_nettype wire

//--- list.f
rtl/analogizer_pkg.sv
rtl/config_bridge.sv
rtl/settings_decode.sv
rtl/sync_polarity_fix.sv
rtl/pixel_capture.sv
rtl/video_mux.sv
rtl/analogizer_top.sv
verification/analogizer_checker.sv
verification/analogizer_tb.sv
